// ==== include/cp0_params.svh ====
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// coprocessor register numbers
`define CP0_BADVADDR 5'd8
`define CP0_COUNT    5'd9
`define CP0_COMPARE  5'd11
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14
`define CP0_PRID     5'd15
`define CP0_CONFIG   5'd16

`define CP0_STATUS_RST 32'h0040_0000 // bev set
`define CP0_CONFIG_VAL 32'h0000_8000
`define CP0_PRID_VAL   32'h004C_0102

`define EXC_VECTOR 32'hBFC0_0380

// excode field values
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_OV   5'd12

`endif

// ==== rtl/cp0_pkg.sv ====
`include "cp0_params.svh"

package cp0_pkg;

	typedef enum logic [4:0] {
		code_int  = `EXC_INT,
		code_adel = `EXC_ADEL,
		code_ades = `EXC_ADES,
		code_sys  = `EXC_SYS,
		code_bp   = `EXC_BP,
		code_ri   = `EXC_RI,
		code_ov   = `EXC_OV
	} excpt_code_t;

	typedef struct packed {
		logic adel_if; // fetch address error
		logic ri;
		logic ov;
		logic sys;
		logic brk;
		logic adel_ld;
		logic ades;
		logic eret;
	} excpt_flags_t;

	typedef struct packed {
		excpt_flags_t flags;
		logic [31:0]  pc;
		logic         in_delay_slot;
		logic [31:0]  bad_addr; // data address of a load/store fault
	} excpt_req_t;

	typedef struct packed {
		logic        valid;
		logic        is_eret;
		excpt_code_t code;
		logic [31:0] epc; // delay slot already folded in
		logic        bd;
		logic        badvaddr_we;
		logic [31:0] badvaddr;
	} excpt_commit_t;

	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} cp0_wr_t;

	typedef struct packed {
		logic [15:0] rsv_31_16; // bev lives in here
		logic [7:0]  im;
		logic [5:0]  rsv_7_2;
		logic        exl;
		logic        ie;
	} status_fields_t;

	typedef union packed {
		logic [31:0]    raw;
		status_fields_t f;
	} status_u;

	typedef struct packed {
		logic        bd;
		logic        ti;
		logic [13:0] rsv_29_16;
		logic [7:0]  ip;
		logic        rsv_7;
		excpt_code_t exc_code;
		logic [1:0]  rsv_1_0;
	} cause_fields_t;

	typedef union packed {
		logic [31:0]   raw;
		cause_fields_t f;
	} cause_u;

endpackage

// ==== rtl/cp0_regs.sv ====
`include "cp0_params.svh"

module cp0_regs (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  cp0_pkg::cp0_wr_t       wr_i,
	input  logic [4:0]             raddr_i,
	input  cp0_pkg::excpt_commit_t commit_i,
	input  logic [5:0]             int_i,
	output logic [31:0]            rdata_o,
	output cp0_pkg::status_u       status_o,
	output cp0_pkg::cause_u        cause_o,
	output logic [31:0]            epc_o,
	output logic [31:0]            count_o,
	output logic                   timer_int_o
);
	import cp0_pkg::*;

	logic [32:0] count_q; // bit 0 halves the rate
	logic [31:0] compare_q;
	status_u     status_q;
	cause_u      cause_q;
	logic [31:0] epc_q;
	logic [31:0] badvaddr_q;
	logic        timer_q;
	logic        timer_hit;
	logic        exc_take;
	logic        eret_take;
	cause_u      cause_view;

	assign count_o   = count_q[32:1];
	assign timer_hit = (compare_q != 32'h0) && (count_q[32:1] == compare_q);
	assign exc_take  = commit_i.valid & ~commit_i.is_eret;
	assign eret_take = commit_i.valid & commit_i.is_eret;

	// timer flag is merged into the visible cause word
	always_comb begin
		cause_view         = cause_q;
		cause_view.f.ti    = timer_q;
		cause_view.f.ip[7] = cause_q.f.ip[7] | timer_q;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count_q      <= '0;
			compare_q    <= '0;
			status_q.raw <= `CP0_STATUS_RST;
			cause_q.raw  <= '0;
			epc_q        <= '0;
			badvaddr_q   <= '0;
			timer_q      <= 1'b0;
		end else if (!stall_i) begin
			count_q           <= count_q + 33'd1;
			cause_q.f.ip[7:2] <= int_i; // hw lines, one edge late
			if (timer_hit) begin
				timer_q <= 1'b1;
			end

			if (wr_i.we) begin
				case (wr_i.addr)
					`CP0_COUNT: begin
						count_q <= {wr_i.data, 1'b0};
					end
					`CP0_COMPARE: begin
						compare_q <= wr_i.data;
						timer_q   <= 1'b0; // acknowledge
					end
					`CP0_STATUS: begin
						status_q.raw <= wr_i.data;
					end
					`CP0_CAUSE: begin
						cause_q.raw[9:8] <= wr_i.data[9:8]; // sw interrupts only
					end
					`CP0_EPC: begin
						epc_q <= wr_i.data;
					end
					default: begin
					end
				endcase
			end

			// commit comes last so it overrides a same-cycle mtc0
			if (exc_take) begin
				status_q.f.exl     <= 1'b1;
				cause_q.f.exc_code <= commit_i.code;
				cause_q.f.bd       <= commit_i.bd;
				epc_q              <= commit_i.epc;
				if (commit_i.badvaddr_we) begin
					badvaddr_q <= commit_i.badvaddr;
				end
			end
			if (eret_take) begin
				status_q.f.exl <= 1'b0;
			end
		end
	end

	// mfc0
	always_comb begin
		case (raddr_i)
			`CP0_COUNT: begin
				rdata_o = count_q[32:1];
			end
			`CP0_COMPARE: begin
				rdata_o = compare_q;
			end
			`CP0_STATUS: begin
				rdata_o = status_q.raw;
			end
			`CP0_CAUSE: begin
				rdata_o = cause_view.raw;
			end
			`CP0_EPC: begin
				rdata_o = epc_q;
			end
			`CP0_PRID: begin
				rdata_o = `CP0_PRID_VAL;
			end
			`CP0_CONFIG: begin
				rdata_o = `CP0_CONFIG_VAL;
			end
			`CP0_BADVADDR: begin
				rdata_o = badvaddr_q;
			end
			default: begin
				rdata_o = 32'h0; // unmapped
			end
		endcase
	end

	assign status_o    = status_q;
	assign cause_o     = cause_view;
	assign epc_o       = epc_q;
	assign timer_int_o = timer_q;

endmodule

// ==== rtl/cp0_top.sv ====
module cp0_top (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 stall_i,
	input  cp0_pkg::excpt_req_t  req_i,
	input  cp0_pkg::cp0_wr_t     wr_i,
	input  logic [4:0]           raddr_i,
	input  logic [5:0]           int_i,
	output logic [31:0]          rdata_o,
	output logic                 flush_o,
	output logic [31:0]          new_pc_o,
	output cp0_pkg::status_u     status_o,
	output cp0_pkg::cause_u      cause_o,
	output logic [31:0]          epc_o,
	output logic [31:0]          count_o,
	output logic                 timer_int_o
);
	import cp0_pkg::*;

	excpt_commit_t commit; // detector decision into the register file

	excpt_detect u_detect (
		.req_i    (req_i),
		.status_i (status_o),
		.cause_i  (cause_o),
		.epc_i    (epc_o),
		.commit_o (commit),
		.flush_o  (flush_o),
		.new_pc_o (new_pc_o)
	);

	cp0_regs u_regs (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.stall_i     (stall_i),
		.wr_i        (wr_i),
		.raddr_i     (raddr_i),
		.commit_i    (commit),
		.int_i       (int_i),
		.rdata_o     (rdata_o),
		.status_o    (status_o),
		.cause_o     (cause_o),
		.epc_o       (epc_o),
		.count_o     (count_o),
		.timer_int_o (timer_int_o)
	);

endmodule

// ==== rtl/excpt_detect.sv ====
`include "cp0_params.svh"

module excpt_detect (
	input  cp0_pkg::excpt_req_t    req_i,
	input  cp0_pkg::status_u       status_i,
	input  cp0_pkg::cause_u        cause_i,
	input  logic [31:0]            epc_i,
	output cp0_pkg::excpt_commit_t commit_o,
	output logic                   flush_o,
	output logic [31:0]            new_pc_o
);
	import cp0_pkg::*;

	logic [7:0]  int_hit;
	logic        int_pending;
	logic        take;
	logic        take_eret;
	excpt_code_t code;
	logic        bv_we;
	logic [31:0] bv_addr;
	logic [31:0] epc_val;

	assign int_hit     = cause_i.f.ip & status_i.f.im;
	assign int_pending = status_i.f.ie & ~status_i.f.exl & (|int_hit);

	// fixed priority, interrupt first and eret last
	always_comb begin
		take      = 1'b1;
		take_eret = 1'b0;
		code      = code_int;
		bv_we     = 1'b0;
		bv_addr   = req_i.pc;
		if (int_pending) begin
			code = code_int;
		end else if (req_i.flags.adel_if) begin
			code    = code_adel;
			bv_we   = 1'b1;
			bv_addr = req_i.pc; // the fetch address itself
		end else if (req_i.flags.ri) begin
			code = code_ri;
		end else if (req_i.flags.ov) begin
			code = code_ov;
		end else if (req_i.flags.sys) begin
			code = code_sys;
		end else if (req_i.flags.brk) begin
			code = code_bp;
		end else if (req_i.flags.adel_ld) begin
			code    = code_adel;
			bv_we   = 1'b1;
			bv_addr = req_i.bad_addr;
		end else if (req_i.flags.ades) begin
			code    = code_ades;
			bv_we   = 1'b1;
			bv_addr = req_i.bad_addr;
		end else if (req_i.flags.eret) begin
			take_eret = 1'b1;
		end else begin
			take = 1'b0;
		end
	end

	// restart at the branch when the faulting instruction sits in its slot
	assign epc_val = req_i.in_delay_slot ? (req_i.pc - 32'd4) : req_i.pc;

	always_comb begin
		commit_o.valid       = take;
		commit_o.is_eret     = take_eret;
		commit_o.code        = code;
		commit_o.epc         = epc_val;
		commit_o.bd          = req_i.in_delay_slot;
		commit_o.badvaddr_we = bv_we;
		commit_o.badvaddr    = bv_addr;
	end

	assign flush_o  = take;
	assign new_pc_o = take_eret ? epc_i : `EXC_VECTOR;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module cp0_tb -o cp0_sim \
	&& ./obj_dir/cp0_sim | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }

// ==== tb/cp0_model_chk.sv ====
`include "cp0_params.svh"

module cp0_model_chk (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                stall_i,
	input  cp0_pkg::excpt_req_t req_i,
	input  cp0_pkg::cp0_wr_t    wr_i,
	input  logic [4:0]          raddr_i,
	input  logic [5:0]          int_i,
	input  logic [3:0]          test_num_i,
	input  logic [31:0]         rdata_i,
	input  logic                flush_i,
	input  logic [31:0]         new_pc_i,
	input  logic [31:0]         status_i,
	input  logic [31:0]         cause_i,
	input  logic [31:0]         epc_i,
	input  logic [31:0]         count_i,
	input  logic                timer_int_i,
	output int                  chk_cnt_o,
	output int                  err_cnt_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// model registers, value after the latest rising edge
	logic [32:0] m_cnt;
	logic [31:0] m_cmp;
	logic [31:0] m_st;
	logic [31:0] m_epc;
	logic [31:0] m_bv;
	logic [5:0]  m_hw;
	logic [1:0]  m_sw;
	logic [4:0]  m_exc;
	logic        m_bd;
	logic        m_tmr;

	logic [7:0]  e_ip;
	logic [31:0] e_cause;
	logic [31:0] e_rd;
	logic [7:0]  fl;
	logic        e_pend;
	logic        e_valid;
	logic        e_eret;
	logic [4:0]  e_code;
	logic        e_bvwe;
	logic [31:0] e_bva;

	int          chk_cnt = 0;
	int          err_cnt = 0;
	int          t_chk = 0;
	int          t_err = 0;
	logic [3:0]  cur_test = 4'd0;

	assign chk_cnt_o = chk_cnt;
	assign err_cnt_o = err_cnt;

	function automatic string test_name(input logic [3:0] n);
		case (n)
			4'd1: return "register access";
			4'd2: return "exception commit";
			4'd3: return "eret";
			4'd4: return "interrupt gating";
			4'd5: return "timer";
			4'd6: return "stall";
			default: return "wrap-up";
		endcase
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chk_cnt++;
		t_chk++;
		if (got !== exp) begin
			err_cnt++;
			t_err++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic reset_model();
		m_cnt = '0;
		m_cmp = '0;
		m_st  = `CP0_STATUS_RST;
		m_epc = '0;
		m_bv  = '0;
		m_hw  = '0;
		m_sw  = '0;
		m_exc = '0;
		m_bd  = 1'b0;
		m_tmr = 1'b0;
	endtask

	task automatic predict();
		e_ip    = {m_hw[5] | m_tmr, m_hw[4:0], m_sw};
		e_cause = {m_bd, m_tmr, 14'h0, e_ip, 1'b0, m_exc, 2'b00};
		e_pend  = m_st[0] && !m_st[1] && ((e_ip & m_st[15:8]) != 8'h0);
		fl      = req_i.flags;
		e_valid = e_pend;
		e_eret  = 1'b0;
		e_code  = `EXC_INT;
		e_bvwe  = 1'b0;
		e_bva   = 32'h0;
		// flag bits already sit in rank order, adel_if at the top
		for (int i = 7; i >= 0; i--) begin
			if (fl[i] && !e_valid) begin
				e_valid = 1'b1;
				case (i)
					7: begin
						e_code = `EXC_ADEL;
						e_bvwe = 1'b1;
						e_bva  = req_i.pc;
					end
					6: e_code = `EXC_RI;
					5: e_code = `EXC_OV;
					4: e_code = `EXC_SYS;
					3: e_code = `EXC_BP;
					2: begin
						e_code = `EXC_ADEL;
						e_bvwe = 1'b1;
						e_bva  = req_i.bad_addr;
					end
					1: begin
						e_code = `EXC_ADES;
						e_bvwe = 1'b1;
						e_bva  = req_i.bad_addr;
					end
					default: e_eret = 1'b1;
				endcase
			end
		end
		case (raddr_i)
			`CP0_COUNT:    e_rd = m_cnt[32:1];
			`CP0_COMPARE:  e_rd = m_cmp;
			`CP0_STATUS:   e_rd = m_st;
			`CP0_CAUSE:    e_rd = e_cause;
			`CP0_EPC:      e_rd = m_epc;
			`CP0_PRID:     e_rd = `CP0_PRID_VAL;
			`CP0_CONFIG:   e_rd = `CP0_CONFIG_VAL;
			`CP0_BADVADDR: e_rd = m_bv;
			default:       e_rd = 32'h0;
		endcase
	endtask

	task automatic advance_model();
		logic hit;
		hit   = (m_cmp != 32'h0) && (m_cnt[32:1] == m_cmp);
		m_cnt = m_cnt + 33'd1;
		m_hw  = int_i;
		if (hit) begin
			m_tmr = 1'b1;
		end
		if (wr_i.we) begin
			case (wr_i.addr)
				`CP0_COUNT:  m_cnt = {wr_i.data, 1'b0};
				`CP0_COMPARE: begin
					m_cmp = wr_i.data;
					m_tmr = 1'b0;
				end
				`CP0_STATUS: m_st = wr_i.data;
				`CP0_CAUSE:  m_sw = wr_i.data[9:8];
				`CP0_EPC:    m_epc = wr_i.data;
				default: begin
				end
			endcase
		end
		if (e_valid && !e_eret) begin // exception wins over mtc0
			m_st[1] = 1'b1;
			m_exc   = e_code;
			m_bd    = req_i.in_delay_slot;
			m_epc   = req_i.in_delay_slot ? req_i.pc - 32'd4 : req_i.pc;
			if (e_bvwe) begin
				m_bv = e_bva;
			end
		end else if (e_eret) begin
			m_st[1] = 1'b0;
		end
	endtask

	// inputs and outputs are settled half a cycle after the drive edge
	always @(negedge clk) begin
		if (test_num_i != cur_test) begin
			if (cur_test != 4'd0) begin
				$display("test %0d (%s): %0d checks, %0d errors",
					cur_test, test_name(cur_test), t_chk, t_err);
			end
			cur_test = test_num_i;
			t_chk    = 0;
			t_err    = 0;
		end
		if (!rst_n_i) begin
			reset_model();
		end else begin
			predict();
			compare_word("flush_o", 32'(flush_i), 32'(e_valid));
			if (e_valid) begin
				compare_word("new_pc_o", new_pc_i, e_eret ? m_epc : `EXC_VECTOR);
			end
			compare_word("rdata_o", rdata_i, e_rd);
			compare_word("status_o", status_i, m_st);
			compare_word("cause_o", cause_i, e_cause);
			compare_word("epc_o", epc_i, m_epc);
			compare_word("count_o", count_i, m_cnt[32:1]);
			compare_word("timer_int_o", 32'(timer_int_i), 32'(m_tmr));
			if (!stall_i) begin
				advance_model();
			end
		end
	end

endmodule

// ==== tb/cp0_props.sv ====
module cp0_props (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   stall_i,
	input  cp0_pkg::excpt_req_t    req_i,
	input  cp0_pkg::excpt_commit_t commit_i,
	input  cp0_pkg::status_u       status_i,
	input  logic                   flush_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;

	// pipeline holds its memory stage quiet while stalled
	no_flags_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |-> (req_i.flags == 8'h0))
		else begin
			$error("exception flags raised while the pipeline is stalled");
			fail_cnt++;
		end

	quiet_in_reset: assert property (@(posedge clk)
		(!rst_n_i && $past(!rst_n_i)) |-> !flush_i)
		else begin
			$error("flush strobe seen during reset");
			fail_cnt++;
		end

	exl_after_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
		(commit_i.valid && !commit_i.is_eret && !stall_i) |=> status_i.f.exl)
		else begin
			$error("EXL still clear after an exception commit");
			fail_cnt++;
		end

endmodule

bind cp0_top cp0_props u_props (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.stall_i  (stall_i),
	.req_i    (req_i),
	.commit_i (commit),
	.status_i (status_o),
	.flush_i  (flush_o)
);

// ==== tb/cp0_tb.sv ====
`include "cp0_params.svh"

module cp0_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cp0_pkg::*;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        stall;
	excpt_req_t  req;
	cp0_wr_t     wr;
	logic [4:0]  raddr;
	logic [5:0]  irq;
	logic [3:0]  test_num;
	logic [31:0] rdata;
	logic        flush;
	logic [31:0] new_pc;
	status_u     status;
	cause_u      cause;
	logic [31:0] epc;
	logic [31:0] count;
	logic        timer_int;
	int          chk_cnt;
	int          err_cnt;
	int          tmo_cnt;

	always #20 clk = ~clk;

	cp0_top DUT (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.stall_i     (stall),
		.req_i       (req),
		.wr_i        (wr),
		.raddr_i     (raddr),
		.int_i       (irq),
		.rdata_o     (rdata),
		.flush_o     (flush),
		.new_pc_o    (new_pc),
		.status_o    (status),
		.cause_o     (cause),
		.epc_o       (epc),
		.count_o     (count),
		.timer_int_o (timer_int)
	);

	cp0_model_chk u_chk (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.stall_i     (stall),
		.req_i       (req),
		.wr_i        (wr),
		.raddr_i     (raddr),
		.int_i       (irq),
		.test_num_i  (test_num),
		.rdata_i     (rdata),
		.flush_i     (flush),
		.new_pc_i    (new_pc),
		.status_i    (status),
		.cause_i     (cause),
		.epc_i       (epc),
		.count_i     (count),
		.timer_int_i (timer_int),
		.chk_cnt_o   (chk_cnt),
		.err_cnt_o   (err_cnt)
	);

	task automatic idle_inputs();
		stall <= 1'b0;
		req   <= '0;
		wr    <= '0;
		raddr <= 5'd0;
		irq   <= 6'd0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		idle_inputs(); // later drives in this step override
	endtask

	task automatic mtc0(input logic [4:0] addr, input logic [31:0] data);
		wr.we   <= 1'b1;
		wr.addr <= addr;
		wr.data <= data;
		next_cycle();
	endtask

	function automatic logic [4:0] pick_addr();
		case ($urandom % 10)
			0: return `CP0_BADVADDR;
			1: return `CP0_COUNT;
			2: return `CP0_COMPARE;
			3: return `CP0_STATUS;
			4: return `CP0_CAUSE;
			5: return `CP0_EPC;
			6: return `CP0_PRID;
			7: return `CP0_CONFIG;
			default: return 5'($urandom);
		endcase
	endfunction

	function automatic logic [7:0] rand_flags();
		if ($urandom % 2 == 1) begin
			return 8'h1 << ($urandom % 8); // single source
		end
		return 8'($urandom);
	endfunction

	task automatic drive_request();
		req.flags         <= rand_flags();
		req.pc            <= $urandom & 32'hFFFF_FFFC;
		req.in_delay_slot <= 1'($urandom);
		req.bad_addr      <= $urandom;
	endtask

	task automatic exercise_registers();
		test_num <= 4'd1;
		repeat (200) begin
			wr.we   <= 1'($urandom);
			wr.addr <= pick_addr();
			wr.data <= $urandom;
			raddr   <= pick_addr();
			next_cycle();
		end
	endtask

	task automatic raise_exceptions();
		test_num <= 4'd2;
		mtc0(`CP0_STATUS, 32'h0); // ie clear
		repeat (200) begin
			drive_request();
			raddr <= ($urandom % 2 == 1) ? `CP0_BADVADDR : `CP0_CAUSE;
			next_cycle();
		end
	endtask

	task automatic return_from_exceptions();
		test_num <= 4'd3;
		repeat (20) begin
			mtc0(`CP0_STATUS, 32'h0000_0002); // exl only
			mtc0(`CP0_EPC, $urandom & 32'hFFFF_FFFC);
			req.flags.eret <= 1'b1;
			req.pc         <= $urandom & 32'hFFFF_FFFC;
			raddr          <= `CP0_STATUS;
			next_cycle();
			raddr <= `CP0_STATUS;
			next_cycle();
		end
	endtask

	task automatic gate_interrupts();
		test_num <= 4'd4;
		repeat (200) begin
			if ($urandom % 4 == 0) begin
				wr.we   <= 1'b1;
				wr.addr <= `CP0_STATUS;
				wr.data <= {16'h0040, 8'($urandom), 6'h0, 2'($urandom)}; // im, exl, ie
			end else if ($urandom % 6 == 0) begin
				wr.we   <= 1'b1;
				wr.addr <= `CP0_CAUSE;
				wr.data <= $urandom;
			end
			irq   <= 6'($urandom);
			raddr <= `CP0_CAUSE;
			next_cycle();
		end
	endtask

	task automatic fire_timer();
		logic [31:0] base;
		logic [31:0] gap;
		int          waited;
		test_num <= 4'd5;
		mtc0(`CP0_STATUS, 32'h0);
		repeat (4) begin
			base = $urandom & 32'h7FFF_FFFF;
			gap  = 32'd3 + ($urandom % 8);
			mtc0(`CP0_COMPARE, 32'h0);
			mtc0(`CP0_COUNT, base);
			mtc0(`CP0_COMPARE, base + gap);
			waited = 0;
			@(negedge clk);
			while (!timer_int && waited < 100) begin
				@(negedge clk);
				waited++;
			end
			if (!timer_int) begin
				tmo_cnt++;
				$display("timeout: timer interrupt never rose after the Compare write");
			end
			@(posedge clk);
			repeat (3) begin
				raddr <= `CP0_COUNT;
				next_cycle();
			end
			mtc0(`CP0_COMPARE, 32'h0); // flag drops here
			next_cycle();
		end
	endtask

	task automatic stall_pipeline();
		logic hold;
		test_num <= 4'd6;
		repeat (200) begin
			hold = 1'($urandom);
			stall   <= hold;
			irq     <= 6'($urandom);
			raddr   <= pick_addr();
			wr.we   <= 1'($urandom);
			wr.addr <= pick_addr();
			wr.data <= $urandom;
			if (!hold && $urandom % 4 == 0) begin
				drive_request();
			end
			next_cycle();
		end
	endtask

	initial begin
		void'($urandom(32'h7b3b_4cb7));
		tmo_cnt = 0;
		rst_n    <= 1'b0;
		test_num <= 4'd0;
		idle_inputs();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		exercise_registers();
		raise_exceptions();
		return_from_exceptions();
		gate_interrupts();
		fire_timer();
		stall_pipeline();
		test_num <= 4'd7;
		next_cycle();
		next_cycle();
		$display("checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
			chk_cnt, err_cnt, tmo_cnt, DUT.u_props.fail_cnt);
		if (chk_cnt > 0 && err_cnt == 0 && tmo_cnt == 0
			&& DUT.u_props.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/cp0_pkg.sv
rtl/excpt_detect.sv
rtl/cp0_regs.sv
rtl/cp0_top.sv
tb/cp0_props.sv
tb/cp0_model_chk.sv
tb/cp0_tb.sv
